// File: Makefile
# Verilator build and run of the shared memory subsystem testbench.

SIM  := obj_dir/Vtb_shared_mem_subsys
SRCS := $(shell cat vlog.f)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes.
$(SIM): vlog.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_shared_mem_subsys -f vlog.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hdl/mem_array.sv
`timescale 1ns/1ps

module mem_array (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  mem_bus_pkg::mem_tagged_req_t  treq_i,
  input  logic                          treq_valid_i,
  output logic                          treq_ready_o,
  output mem_bus_pkg::mem_tagged_rsp_t  trsp_o,
  output logic                          trsp_valid_o,
  input  logic                          trsp_ready_i
);

  import mem_cfg_pkg::*;
  import mem_bus_pkg::*;

  logic [DATA_W-1:0] mem_q [MEM_DEPTH];  // Shared storage.
  mem_req_t          req;                // Unwrapped request.
  logic              accept;             // Request transfer this edge.
  logic              is_read;            // Read opcode decoded.

  assign req     = treq_i.req;
  assign is_read = (req.op == OP_READ);

  // Writes also wait for the output slot, which keeps the pipeline in order.
  assign treq_ready_o = !trsp_valid_o || trsp_ready_i;
  assign accept       = treq_valid_i && treq_ready_o;

  // RAM port. Read and write share one address per cycle.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      case (req.op)
        OP_WRITE: begin
          for (int b = 0; b < STRB_W; b++) begin
            if (req.strb[b]) begin
              mem_q[req.addr][8*b +: 8] <= req.wdata[8*b +: 8];  // Enabled lane only.
            end
          end
        end
        OP_READ: begin
          trsp_o.rsp.rdata <= mem_q[req.addr];  // Registered read data.
          trsp_o.src       <= treq_i.src;       // Return address for the router.
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      trsp_valid_o <= 1'b0;
    end else if (accept) begin
      trsp_valid_o <= is_read;  // A write leaves no response.
    end else if (trsp_ready_i) begin
      trsp_valid_o <= 1'b0;  // Response taken.
    end
  end

endmodule

// File: hdl/mem_bus_pkg.sv
package mem_bus_pkg;

  import mem_cfg_pkg::*;

  // One-beat access type.
  typedef enum logic {
    OP_READ  = 1'b0,  // Fetch a word.
    OP_WRITE = 1'b1   // Strobed store.
  } mem_op_e;

  typedef struct packed {
    mem_op_e           op;     // Access type.
    logic [ADDR_W-1:0] addr;   // Word address.
    logic [DATA_W-1:0] wdata;  // Ignored on reads.
    logic [STRB_W-1:0] strb;   // Byte enables for writes.
  } mem_req_t;

  // Request after arbitration, carrying its origin.
  typedef struct packed {
    mem_req_t         req;
    logic [SRC_W-1:0] src;     // Issuing port.
  } mem_tagged_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;  // Read word.
  } mem_rsp_t;

  // Read data on its way back to the issuing port.
  typedef struct packed {
    mem_rsp_t         rsp;
    logic [SRC_W-1:0] src;     // Destination port.
  } mem_tagged_rsp_t;

endpackage

// File: hdl/mem_cfg_pkg.sv
package mem_cfg_pkg;

  // Shared RAM geometry.
  localparam int MEM_DEPTH = 1024;               // Words of storage.
  localparam int ADDR_W    = $clog2(MEM_DEPTH);  // Word address, 10 bits.
  localparam int DATA_W    = 32;                 // Word width.
  localparam int STRB_W    = DATA_W / 8;         // One strobe per byte lane.

  // Requester side.
  localparam int PORT_N    = 2;                  // DMA master and host port.
  localparam int SRC_W     = 1;                  // Tag wide enough for PORT_N.

endpackage

// File: hdl/mem_req_arbiter.sv
`timescale 1ns/1ps

module mem_req_arbiter (
  input  logic                                            clk_i,
  input  logic                                            rst_i,
  input  mem_bus_pkg::mem_req_t [mem_cfg_pkg::PORT_N-1:0] req_i,
  input  logic                  [mem_cfg_pkg::PORT_N-1:0] req_valid_i,
  output logic                  [mem_cfg_pkg::PORT_N-1:0] req_ready_o,
  output mem_bus_pkg::mem_tagged_req_t                    treq_o,
  output logic                                            treq_valid_o,
  input  logic                                            treq_ready_i
);

  import mem_cfg_pkg::*;
  import mem_bus_pkg::*;

  logic [PORT_N-1:0] gnt;         // One-hot winner this cycle.
  logic              last_gnt_q;  // Set when port 1 won last.
  logic              stage_free;  // Output register empty or leaving.
  logic              accept;      // Some port hands over a request.
  logic [SRC_W-1:0]  src_sel;     // Tag of the winner.
  mem_req_t          req_sel;     // Winning request.

  assign stage_free = !treq_valid_o || treq_ready_i;  // Slot reusable this edge.

  // Round robin over two ports needs only the last winner.
  assign gnt[0] = req_valid_i[0] && (!req_valid_i[1] || last_gnt_q);   // Port 0 turn.
  assign gnt[1] = req_valid_i[1] && (!req_valid_i[0] || !last_gnt_q);  // Port 1 turn.

  // A waiting loser sees ready low; an idle port sees the stage state.
  assign req_ready_o = {PORT_N{stage_free}} & (gnt | ~req_valid_i);

  assign accept  = stage_free && (|gnt);                 // Handshake on the winner.
  assign src_sel = gnt[1] ? SRC_W'(1) : SRC_W'(0);       // Encode the grant.
  assign req_sel = req_i[src_sel];                       // Mux the winning payload.

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      treq_valid_o <= 1'b0;
      last_gnt_q   <= 1'b1;  // Makes port 0 win the first tie.
    end else if (accept) begin
      treq_valid_o <= 1'b1;
      last_gnt_q   <= gnt[1];  // Remember who got in.
    end else if (treq_ready_i) begin
      treq_valid_o <= 1'b0;  // Drained with nothing behind it.
    end
  end

  // Payload register, loaded only on a handshake so it holds while stalled.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      treq_o.req <= req_sel;
      treq_o.src <= src_sel;  // Tag follows the request.
    end
  end

endmodule

// File: hdl/mem_resp_router.sv
`timescale 1ns/1ps

module mem_resp_router (
  input  logic                                            clk_i,
  input  logic                                            rst_i,
  input  mem_bus_pkg::mem_tagged_rsp_t                    trsp_i,
  input  logic                                            trsp_valid_i,
  output logic                                            trsp_ready_o,
  output mem_bus_pkg::mem_rsp_t [mem_cfg_pkg::PORT_N-1:0] rsp_o,
  output logic                  [mem_cfg_pkg::PORT_N-1:0] rsp_valid_o,
  input  logic                  [mem_cfg_pkg::PORT_N-1:0] rsp_ready_i
);

  import mem_cfg_pkg::*;
  import mem_bus_pkg::*;

  logic [SRC_W-1:0]  tgt;   // Destination of the incoming response.
  logic [PORT_N-1:0] load;  // Per-port register write enable.

  assign tgt = trsp_i.src;

  // Only the addressed register matters, so one full port stalls everything.
  assign trsp_ready_o = !rsp_valid_o[tgt] || rsp_ready_i[tgt];

  for (genvar p = 0; p < PORT_N; p++) begin : g_port
    logic     vld_q;  // Register holds an undelivered word.
    mem_rsp_t rsp_q;  // Held response payload.

    assign load[p] = trsp_valid_i && trsp_ready_o && (tgt == SRC_W'(p));  // Ours.

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        vld_q <= 1'b0;
      end else if (load[p]) begin
        vld_q <= 1'b1;  // Refill, possibly while draining.
      end else if (rsp_ready_i[p]) begin
        vld_q <= 1'b0;  // Delivered.
      end
    end

    // Steady while waiting for the port to take it.
    always_ff @(posedge clk_i) begin
      if (load[p]) begin
        rsp_q <= trsp_i.rsp;
      end
    end

    assign rsp_o[p]       = rsp_q;
    assign rsp_valid_o[p] = vld_q;
  end

endmodule

// File: hdl/shared_mem_subsys.sv
`timescale 1ns/1ps

module shared_mem_subsys (
  input  logic                                            clk_i,
  input  logic                                            rst_i,
  input  mem_bus_pkg::mem_req_t [mem_cfg_pkg::PORT_N-1:0] req_i,
  input  logic                  [mem_cfg_pkg::PORT_N-1:0] req_valid_i,
  output logic                  [mem_cfg_pkg::PORT_N-1:0] req_ready_o,
  output mem_bus_pkg::mem_rsp_t [mem_cfg_pkg::PORT_N-1:0] rsp_o,
  output logic                  [mem_cfg_pkg::PORT_N-1:0] rsp_valid_o,
  input  logic                  [mem_cfg_pkg::PORT_N-1:0] rsp_ready_i
);

  import mem_bus_pkg::*;

  mem_tagged_req_t treq;        // Arbiter to RAM.
  logic            treq_valid;
  logic            treq_ready;
  mem_tagged_rsp_t trsp;        // RAM to router.
  logic            trsp_valid;
  logic            trsp_ready;

  // Port 0 is the DMA master, port 1 the host access port.
  mem_req_arbiter u_mem_req_arbiter (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .treq_o       (treq),
    .treq_valid_o (treq_valid),
    .treq_ready_i (treq_ready)
  );

  mem_array u_mem_array (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .treq_i       (treq),
    .treq_valid_i (treq_valid),
    .treq_ready_o (treq_ready),
    .trsp_o       (trsp),
    .trsp_valid_o (trsp_valid),
    .trsp_ready_i (trsp_ready)
  );

  mem_resp_router u_mem_resp_router (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .trsp_i       (trsp),
    .trsp_valid_i (trsp_valid),
    .trsp_ready_o (trsp_ready),
    .rsp_o        (rsp_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i)
  );

endmodule

// File: testbench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_NS    = 20;  // 40 ns period.
  localparam int RST_CYCLES = 3;   // Rising edges spent in reset.

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_NS) clk_o = ~clk_o;
    end
  end

  // Synchronous reset, released on an edge like any other driven input.
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// File: testbench/tb_shared_mem_subsys.sv
`timescale 1ns/1ps

module tb_shared_mem_subsys;

  import mem_cfg_pkg::*;
  import mem_bus_pkg::*;

  localparam int TIMEOUT_CYCLES = 4000;  // All tests need a few hundred cycles.

  logic                    clk;
  logic                    rst;
  mem_req_t [PORT_N-1:0]   req_i;
  logic     [PORT_N-1:0]   req_valid_i;
  logic     [PORT_N-1:0]   req_ready_o;
  mem_rsp_t [PORT_N-1:0]   rsp_o;
  logic     [PORT_N-1:0]   rsp_valid_o;
  logic     [PORT_N-1:0]   rsp_ready_i;

  mem_req_t          pend_q [PORT_N][$];        // Requests not yet accepted.
  logic [DATA_W-1:0] exp_q [PORT_N][$];         // Read data still owed per port.
  logic [DATA_W-1:0] model_mem [MEM_DEPTH];     // Reference RAM.
  logic [DATA_W-1:0] held_rsp [PORT_N];         // Payload seen while stalled.
  logic [PORT_N-1:0] held_stall = '0;           // Valid high, ready low last sample.
  logic              last_gnt   = 1'b1;         // Port 0 wins the first tie.
  logic              bp_on      = 1'b0;         // Random response ready.
  logic [31:0]       lfsr_q     = 32'hbd4f_2690;
  int                first_tie  = -1;           // Winner of the first tie seen.
  int                tie_n      = 0;
  int                stall_n    = 0;
  int                step_n     = 0;
  int                cycle_n    = 0;
  int                mismatch_n = 0;
  int                other_n    = 0;

  tb_clk_gen u_tb_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  shared_mem_subsys u_shared_mem_subsys (
    .clk_i       (clk),
    .rst_i       (rst),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
  );

  task automatic compare_value(input string what, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] want);
    if (got !== want) begin
      mismatch_n++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", what, got, want);
    end
  endtask

  task automatic flag_error(input string msg);
    other_n++;
    $display("ERROR %s", msg);
  endtask

  // Galois LFSR stepped once per bit handed out.
  function automatic logic [31:0] random_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
      val    = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  function automatic mem_req_t write_req(input logic [ADDR_W-1:0] addr,
                                         input logic [DATA_W-1:0] data,
                                         input logic [STRB_W-1:0] strb);
    mem_req_t r;
    r.op    = OP_WRITE;
    r.addr  = addr;
    r.wdata = data;
    r.strb  = strb;
    return r;
  endfunction

  function automatic mem_req_t read_req(input logic [ADDR_W-1:0] addr);
    mem_req_t r;
    r.op    = OP_READ;
    r.addr  = addr;
    r.wdata = '0;
    r.strb  = '0;
    return r;
  endfunction

  // Mid-cycle look at the DUT; a handshake seen here completes on the next edge.
  task automatic sample();
    mem_req_t          r;
    logic [PORT_N-1:0] want;
    logic [DATA_W-1:0] want_data;
    for (int p = 0; p < PORT_N; p++) begin
      if (held_stall[p]) begin
        if (!rsp_valid_o[p]) begin
          flag_error($sformatf("port %0d dropped its response before it was taken", p));
        end
        compare_value($sformatf("rsp_o[%0d] while stalled", p), rsp_o[p].rdata, held_rsp[p]);
      end
      if (rsp_valid_o[p] && rsp_ready_i[p]) begin
        if (exp_q[p].size() == 0) begin
          flag_error($sformatf("port %0d returned data that was never requested", p));
        end else begin
          want_data = exp_q[p].pop_front();  // Oldest read of this port.
          compare_value($sformatf("rsp_o[%0d].rdata", p), rsp_o[p].rdata, want_data);
        end
      end
      if (rsp_valid_o[p] && !rsp_ready_i[p]) begin
        stall_n++;
      end
      held_stall[p] = rsp_valid_o[p] && !rsp_ready_i[p];
      held_rsp[p]   = rsp_o[p].rdata;
    end
    // Tie between the ports goes to the one not granted last.
    if ((&req_valid_i) && (|req_ready_o)) begin
      want = last_gnt ? 2'b01 : 2'b10;
      compare_value("req_ready_o on tie", DATA_W'(req_ready_o), DATA_W'(want));
      if (first_tie < 0) begin
        first_tie = req_ready_o[1] ? 1 : 0;  // As granted by the DUT.
      end
      tie_n++;
    end
    for (int p = 0; p < PORT_N; p++) begin
      if (req_valid_i[p] && req_ready_o[p]) begin
        if (pend_q[p].size() == 0) begin
          flag_error($sformatf("port %0d accepted a request that was not driven", p));
        end else begin
          r        = pend_q[p].pop_front();
          last_gnt = (p == 1);
          if (r.op == OP_WRITE) begin
            for (int b = 0; b < STRB_W; b++) begin
              if (r.strb[b]) begin
                model_mem[r.addr][8*b +: 8] = r.wdata[8*b +: 8];  // Lane merge.
              end
            end
          end else begin
            exp_q[p].push_back(model_mem[r.addr]);  // Order kept by the pipeline.
          end
        end
      end
    end
  endtask

  // Drives on the rising edge and looks on the falling one.
  task automatic step();
    @(posedge clk);
    for (int p = 0; p < PORT_N; p++) begin
      if (pend_q[p].size() != 0) begin
        req_valid_i[p] <= 1'b1;
        req_i[p]       <= pend_q[p][0];  // Head stays until accepted.
      end else begin
        req_valid_i[p] <= 1'b0;
      end
    end
    if (bp_on) begin
      rsp_ready_i <= PORT_N'(random_bits(PORT_N));
    end else begin
      rsp_ready_i <= '1;
    end
    @(negedge clk);
    step_n++;
    sample();
  endtask

  function automatic logic busy();
    logic b;
    b = (req_valid_i != '0);
    for (int p = 0; p < PORT_N; p++) begin
      b |= (pend_q[p].size() != 0) || (exp_q[p].size() != 0);
    end
    return b;
  endfunction

  task automatic run_until_idle();
    while (busy()) begin
      step();
    end
  endtask

  task automatic check_reset_state();
    compare_value("rsp_valid_o after reset", DATA_W'(rsp_valid_o), '0);
    compare_value("req_ready_o after reset", DATA_W'(req_ready_o), DATA_W'(2'b11));
  endtask

  task automatic alternate_grants();
    tie_n = 0;
    for (int i = 0; i < 4; i++) begin
      pend_q[0].push_back(write_req(ADDR_W'('h100 + i), random_bits(DATA_W), '1));
      pend_q[1].push_back(write_req(ADDR_W'('h200 + i), random_bits(DATA_W), '1));
    end
    for (int i = 0; i < 4; i++) begin
      pend_q[0].push_back(read_req(ADDR_W'('h100 + i)));
      pend_q[1].push_back(read_req(ADDR_W'('h200 + i)));
    end
    run_until_idle();
    compare_value("first tie winner", DATA_W'(first_tie), '0);
    compare_value("tied grants", DATA_W'(tie_n), DATA_W'(15));  // Last one is alone.
  endtask

  task automatic write_read_port1();
    logic [ADDR_W-1:0] addr [6];
    int                start;
    for (int i = 0; i < 6; i++) begin
      addr[i] = ADDR_W'(random_bits(ADDR_W));
      pend_q[1].push_back(write_req(addr[i], random_bits(DATA_W), '1));
    end
    for (int i = 0; i < 6; i++) begin
      pend_q[1].push_back(read_req(addr[i]));
    end
    run_until_idle();
    // Lone read through an empty pipeline.
    pend_q[1].push_back(read_req(addr[0]));
    while (pend_q[1].size() != 0) begin
      step();
    end
    start = step_n;
    step();
    while (!rsp_valid_o[1]) begin
      step();
    end
    compare_value("read latency in cycles", DATA_W'(step_n - start), DATA_W'(3));
    run_until_idle();
  endtask

  task automatic merge_byte_strobes();
    logic [STRB_W-1:0] strb_set [4];
    logic [ADDR_W-1:0] addr;
    strb_set = '{4'b0101, 4'b1000, 4'b0000, 4'b0110};
    addr     = ADDR_W'('h155);
    pend_q[0].push_back(write_req(addr, random_bits(DATA_W), '1));  // Known base word.
    for (int i = 0; i < 4; i++) begin
      pend_q[0].push_back(write_req(addr, random_bits(DATA_W), strb_set[i]));
      pend_q[0].push_back(read_req(addr));
    end
    run_until_idle();
  endtask

  task automatic read_after_write();
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    addr = ADDR_W'('h100);  // Written by the arbitration test.
    data = model_mem[addr] ^ (random_bits(DATA_W) | 32'h1);  // Surely new.
    pend_q[0].push_back(write_req(addr, data, '1));
    while (pend_q[0].size() != 0) begin
      step();
    end
    pend_q[1].push_back(read_req(addr));
    step();
    compare_value("port 1 reads still waiting", DATA_W'(pend_q[1].size()), '0);
    run_until_idle();
  endtask

  task automatic random_back_pressure();
    logic [ADDR_W-1:0] addr [32];
    int                port;
    for (int i = 0; i < 32; i++) begin
      addr[i] = ADDR_W'(random_bits(ADDR_W));
      pend_q[i % 2].push_back(write_req(addr[i], random_bits(DATA_W), '1));
    end
    run_until_idle();
    stall_n = 0;
    bp_on   = 1'b1;
    for (int i = 0; i < 32; i++) begin
      port = int'(random_bits(1));
      pend_q[port].push_back(read_req(addr[i]));
    end
    run_until_idle();
    bp_on = 1'b0;
    if (stall_n == 0) begin
      flag_error("back-pressure never held a response");
    end
  endtask

  // Watchdog that runs on the clock alone.
  always @(posedge clk) begin
    cycle_n++;
    if (cycle_n >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_n);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    req_valid_i <= '0;
    req_i       <= '0;
    rsp_ready_i <= '1;
    @(negedge clk);
    while (rst) begin
      @(negedge clk);
    end
    check_reset_state();
    alternate_grants();      // Runs first so the reset priority is visible.
    write_read_port1();
    merge_byte_strobes();
    read_after_write();
    random_back_pressure();
    $display("Summary: %0d value mismatches, %0d other errors", mismatch_n, other_n);
    if (mismatch_n == 0 && other_n == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
hdl/mem_cfg_pkg.sv
hdl/mem_bus_pkg.sv
hdl/mem_req_arbiter.sv
hdl/mem_array.sv
hdl/mem_resp_router.sv
hdl/shared_mem_subsys.sv
testbench/tb_clk_gen.sv
testbench/tb_shared_mem_subsys.sv
